// File: hdl/matmul_defines.svh
//////////////////////////////////////////////////////////////////////
// Size parameters of the matrix-vector accelerator
// Included by every RTL file and by the testbench
//////////////////////////////////////////////////////////////////////

`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// Lanes per word, also the number of accumulate steps per job
`define MM_LANES 4

// Width of one element
`define MM_ELEM_W 16

// Stream word holds one element per lane
`define MM_WORD_W (`MM_LANES * `MM_ELEM_W)

// FIFO depths in words, W holds the rows of two jobs
`define MM_XY_DEPTH 2
`define MM_W_DEPTH 8

`define MM_STEP_W 2

`endif

// File: hdl/matmul_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types of the matrix-vector accelerator
// Imported by the modules that carry stream words
//////////////////////////////////////////////////////////////////////

`include "matmul_defines.svh"

package matmul_pkg;

  // Stream word, seen either as flat storage or split into elements
  // Element 0 sits in the low bits
  typedef union packed {
    logic [`MM_WORD_W-1:0] raw;
    logic [`MM_LANES-1:0][`MM_ELEM_W-1:0] elem;
  } mm_word_u;

endpackage

// File: hdl/stream_fifo.sv
//////////////////////////////////////////////////////////////////////
// Word FIFO for the X, W and Y input streams
// Filled by a one-cycle push strobe, drained by the job scheduler
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module stream_fifo
  import matmul_pkg::*;
#(
  parameter int unsigned DEPTH = 2
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  mm_word_u data_i,
  input  logic     pop_i,
  output mm_word_u data_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  mm_word_u mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic do_pop;

  // A pop on an empty FIFO is ignored
  assign do_pop  = pop_i & ~empty_o;
  assign empty_o = (count_q == '0);
  assign data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      if (push_i && !do_pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (!push_i && do_pop) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

endmodule

// File: hdl/x_buffer.sv
//////////////////////////////////////////////////////////////////////
// X word holding register for the accumulate steps
// Loaded at job start, shifted once per accumulated W row
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module x_buffer
  import matmul_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  load_i,
  input  logic                  shift_i,
  input  mm_word_u              data_i,
  output logic [`MM_ELEM_W-1:0] x_elem_o
);

  mm_word_u buf_q;

  // Lowest element is the scalar of the current step
  assign x_elem_o = buf_q.elem[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      buf_q <= '0;
    end else if (load_i) begin
      buf_q <= data_i;
    end else if (shift_i) begin
      // Next element drops into lane 0
      buf_q.raw <= buf_q.raw >> `MM_ELEM_W;
    end
  end

endmodule

// File: hdl/mac_lanes.sv
//////////////////////////////////////////////////////////////////////
// Integer MAC lanes of the accelerator
// Start from the Y bias and add X scalar times W row on each step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module mac_lanes
  import matmul_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  load_i,
  input  logic                  acc_en_i,
  input  mm_word_u              bias_i,
  input  logic [`MM_ELEM_W-1:0] x_elem_i,
  input  mm_word_u              w_row_i,
  output mm_word_u              z_o
);

  mm_word_u acc_q;
  mm_word_u acc_sum;
  logic [`MM_LANES-1:0][`MM_ELEM_W-1:0] prod;

  // One multiplier per lane with the scalar shared by all lanes
  always_comb begin
    for (int j = 0; j < `MM_LANES; j++) begin
      // Product and sum both wrap modulo the element width
      prod[j] = x_elem_i * w_row_i.elem[j];
      acc_sum.elem[j] = acc_q.elem[j] + prod[j];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (load_i) begin
      acc_q <= bias_i;
    end else if (acc_en_i) begin
      acc_q <= acc_sum;
    end
  end

  assign z_o = acc_q;

endmodule

// File: hdl/job_scheduler.sv
//////////////////////////////////////////////////////////////////////
// Job sequencing FSM of the accelerator
// Load X and Y, accumulate one W row per step, then strobe Z
// Instantiated twice at the top for lockstep checking
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module job_scheduler (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  x_empty_i,
  input  logic                  y_empty_i,
  input  logic                  w_empty_i,
  output logic                  load_o,
  output logic                  w_pop_o,
  output logic                  z_valid_o,
  output logic                  busy_o,
  output logic [`MM_STEP_W-1:0] step_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ACC  = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic [`MM_STEP_W-1:0] step_q;
  logic [`MM_STEP_W-1:0] step_d;
  logic last_step;

  assign last_step = (step_q == `MM_STEP_W'(`MM_LANES - 1));

  // Job starts once both X and Y are waiting
  assign load_o    = (state_q == ST_IDLE) & ~x_empty_i & ~y_empty_i;
  // Steps stall while no W row is queued
  assign w_pop_o   = (state_q == ST_ACC) & ~w_empty_i;
  assign z_valid_o = (state_q == ST_DONE);
  assign busy_o    = (state_q != ST_IDLE) | load_o;
  assign step_o    = step_q;

  always_comb begin
    state_d = state_q;
    step_d  = step_q;
    case (state_q)
      ST_IDLE: begin
        if (load_o) begin
          state_d = ST_ACC;
          step_d  = '0;
        end
      end
      ST_ACC: begin
        if (w_pop_o) begin
          step_d = step_q + `MM_STEP_W'(1);
          if (last_step) begin
            state_d = ST_DONE;
          end
        end
      end
      // Accumulators settled, Z shown for this cycle only
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      step_q  <= '0;
    end else begin
      state_q <= state_d;
      step_q  <= step_d;
    end
  end

endmodule

// File: hdl/lockstep_checker.sv
//////////////////////////////////////////////////////////////////////
// Lockstep comparator for the two scheduler replicas
// Any difference in one cycle sets a fault that holds until reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module lockstep_checker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  a_load_i,
  input  logic                  a_w_pop_i,
  input  logic                  a_z_valid_i,
  input  logic                  a_busy_i,
  input  logic [`MM_STEP_W-1:0] a_step_i,
  input  logic                  b_load_i,
  input  logic                  b_w_pop_i,
  input  logic                  b_z_valid_i,
  input  logic                  b_busy_i,
  input  logic [`MM_STEP_W-1:0] b_step_i,
  output logic                  fault_o
);

  logic mismatch;
  logic fault_q;

  assign mismatch = (a_load_i != b_load_i) | (a_w_pop_i != b_w_pop_i) |
                    (a_z_valid_i != b_z_valid_i) | (a_busy_i != b_busy_i) |
                    (a_step_i != b_step_i);

  // Sticky until the next reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fault_q <= 1'b0;
    end else if (mismatch) begin
      fault_q <= 1'b1;
    end
  end

  assign fault_o = fault_q;

endmodule

// File: hdl/matmul_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the lockstep matrix-vector accelerator
// Takes Y, X and W words on strobes and returns one Z word per job
// Replica 0 of the scheduler drives the datapath, replica 1 is checked
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module matmul_top
  import matmul_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     x_valid_i,
  input  mm_word_u x_data_i,
  input  logic     w_valid_i,
  input  mm_word_u w_data_i,
  input  logic     y_valid_i,
  input  mm_word_u y_data_i,
  output logic     z_valid_o,
  output mm_word_u z_data_o,
  output logic     busy_o,
  output logic     fault_o
);

  mm_word_u x_head;
  mm_word_u w_head;
  mm_word_u y_head;
  logic x_empty;
  logic w_empty;
  logic y_empty;
  logic [`MM_ELEM_W-1:0] x_elem;

  // Replica 0 outputs
  logic load;
  logic w_pop;
  logic [`MM_STEP_W-1:0] step;

  // Replica 1 outputs, seen only by the checker
  logic b_load;
  logic b_w_pop;
  logic b_z_valid;
  logic b_busy;
  logic [`MM_STEP_W-1:0] b_step;

  stream_fifo #(.DEPTH(`MM_XY_DEPTH)) i_x_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (x_valid_i),
    .data_i  (x_data_i),
    .pop_i   (load),
    .data_o  (x_head),
    .empty_o (x_empty)
  );

  stream_fifo #(.DEPTH(`MM_W_DEPTH)) i_w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_valid_i),
    .data_i  (w_data_i),
    .pop_i   (w_pop),
    .data_o  (w_head),
    .empty_o (w_empty)
  );

  stream_fifo #(.DEPTH(`MM_XY_DEPTH)) i_y_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (y_valid_i),
    .data_i  (y_data_i),
    .pop_i   (load),
    .data_o  (y_head),
    .empty_o (y_empty)
  );

  x_buffer i_x_buffer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .shift_i  (w_pop),
    .data_i   (x_head),
    .x_elem_o (x_elem)
  );

  // The W pop strobe doubles as the accumulate enable
  mac_lanes i_mac_lanes (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .acc_en_i (w_pop),
    .bias_i   (y_head),
    .x_elem_i (x_elem),
    .w_row_i  (w_head),
    .z_o      (z_data_o)
  );

  job_scheduler i_scheduler_0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .x_empty_i (x_empty),
    .y_empty_i (y_empty),
    .w_empty_i (w_empty),
    .load_o    (load),
    .w_pop_o   (w_pop),
    .z_valid_o (z_valid_o),
    .busy_o    (busy_o),
    .step_o    (step)
  );

  job_scheduler i_scheduler_1 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .x_empty_i (x_empty),
    .y_empty_i (y_empty),
    .w_empty_i (w_empty),
    .load_o    (b_load),
    .w_pop_o   (b_w_pop),
    .z_valid_o (b_z_valid),
    .busy_o    (b_busy),
    .step_o    (b_step)
  );

  lockstep_checker i_checker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .a_load_i    (load),
    .a_w_pop_i   (w_pop),
    .a_z_valid_i (z_valid_o),
    .a_busy_i    (busy_o),
    .a_step_i    (step),
    .b_load_i    (b_load),
    .b_w_pop_i   (b_w_pop),
    .b_z_valid_i (b_z_valid),
    .b_busy_i    (b_busy),
    .b_step_i    (b_step),
    .fault_o     (fault_o)
  );

endmodule

// File: verification/tb_matmul_top.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the matrix-vector accelerator top level
// Sends random and edge-value jobs, checks every Z word in order
// against a reference model and watches the lockstep fault flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

`include "matmul_defines.svh"

module tb_matmul_top
  import matmul_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_B2B      = 8;
  localparam int NUM_GAP      = 8;
  localparam int NUM_EDGE     = 4;
  localparam int TOTAL_JOBS   = 1 + NUM_B2B + NUM_GAP + NUM_EDGE;
  localparam int MAX_GAP      = 5;
  // Load, one step per row with the longest gap, Z strobe and some slack
  localparam int JOB_CYCLES     = 2 + `MM_LANES * (MAX_GAP + 1) + 4;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * TOTAL_JOBS * JOB_CYCLES + 200;

  logic clk;
  logic rst_n;
  logic x_valid;
  logic w_valid;
  logic y_valid;
  mm_word_u x_data;
  mm_word_u w_data;
  mm_word_u y_data;
  logic z_valid;
  mm_word_u z_data;
  logic busy;
  logic fault;

  logic [31:0] lfsr_q = 32'hcee405af;
  mm_word_u expected_q[$];
  mm_word_u exp_word;
  int jobs_sent = 0;
  int z_count = 0;
  int checks = 0;
  int errors = 0;
  bit fault_seen = 1'b0;
  string cur_test = "reset";

  matmul_top dut0 (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .x_valid_i (x_valid),
    .x_data_i  (x_data),
    .w_valid_i (w_valid),
    .w_data_i  (w_data),
    .y_valid_i (y_valid),
    .y_data_i  (y_data),
    .z_valid_o (z_valid),
    .z_data_o  (z_data),
    .busy_o    (busy),
    .fault_o   (fault)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Galois form of x^32 + x^22 + x^2 + x + 1 shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // Z[j] = Y[j] + sum over k of X[k] * W_k[j] modulo the element width
  function automatic mm_word_u ref_z(input mm_word_u y, input mm_word_u x,
                                     input logic [`MM_LANES-1:0][`MM_WORD_W-1:0] w);
    mm_word_u z;
    logic [`MM_ELEM_W-1:0] acc;
    logic [2*`MM_ELEM_W-1:0] p;
    z.raw = '0;
    for (int j = 0; j < `MM_LANES; j++) begin
      acc = y.raw[j*`MM_ELEM_W +: `MM_ELEM_W];
      for (int k = 0; k < `MM_LANES; k++) begin
        p = (2*`MM_ELEM_W)'(x.raw[k*`MM_ELEM_W +: `MM_ELEM_W]) *
            (2*`MM_ELEM_W)'(w[k][j*`MM_ELEM_W +: `MM_ELEM_W]);
        acc = acc + p[`MM_ELEM_W-1:0];
      end
      z.raw[j*`MM_ELEM_W +: `MM_ELEM_W] = acc;
    end
    return z;
  endfunction

  task automatic random_job(output mm_word_u y, output mm_word_u x,
                            output logic [`MM_LANES-1:0][`MM_WORD_W-1:0] w);
    logic [63:0] r;
    rand_bits(`MM_WORD_W, r);
    y.raw = r;
    rand_bits(`MM_WORD_W, r);
    x.raw = r;
    for (int k = 0; k < `MM_LANES; k++) begin
      rand_bits(`MM_WORD_W, r);
      w[k] = r;
    end
  endtask

  // Called on a falling edge and keeps at most two jobs outstanding
  task automatic send_job(input mm_word_u y, input mm_word_u x,
                          input logic [`MM_LANES-1:0][`MM_WORD_W-1:0] w,
                          input int max_gap);
    logic [63:0] r;
    int gap;
    while (jobs_sent - z_count >= 2) begin
      @(negedge clk);
    end
    expected_q.push_back(ref_z(y, x, w));
    jobs_sent++;
    y_valid = 1'b1;
    y_data  = y;
    x_valid = 1'b1;
    x_data  = x;
    for (int k = 0; k < `MM_LANES; k++) begin
      gap = 0;
      if (k > 0 && max_gap > 0) begin
        rand_bits(3, r);
        gap = int'(r[2:0]) % (max_gap + 1);
      end
      repeat (gap) @(negedge clk);
      w_valid    = 1'b1;
      w_data.raw = w[k];
      @(negedge clk);
      x_valid = 1'b0;
      y_valid = 1'b0;
      w_valid = 1'b0;
    end
  endtask

  task automatic drain_and_check();
    while (z_count != jobs_sent) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    check_value({cur_test, " busy after drain"}, 64'(0), 64'(busy));
    check_value({cur_test, " z strobe count"}, 64'(jobs_sent), 64'(z_count));
  endtask

  // Compare each Z strobe with the oldest expected word
  always @(posedge clk) begin
    if (rst_n) begin
      if (z_valid) begin
        z_count++;
        check_value({cur_test, " busy during z"}, 64'(1), 64'(busy));
        if (expected_q.size() == 0) begin
          errors++;
          $display("Z strobe in test %s while no job was outstanding", cur_test);
        end else begin
          exp_word = expected_q.pop_front();
          check_value({cur_test, " z data"}, exp_word.raw, z_data.raw);
        end
      end
      if (fault && !fault_seen) begin
        fault_seen = 1'b1;
        errors++;
        $display("Lockstep fault raised during test %s", cur_test);
      end
    end
  end

  initial begin
    #(CLK_PERIOD * TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles with %0d of %0d jobs returned",
             TIMEOUT_CYCLES, z_count, jobs_sent);
    $display("tests failed");
    $finish;
  end

  initial begin
    mm_word_u y;
    mm_word_u x;
    logic [`MM_LANES-1:0][`MM_WORD_W-1:0] w;
    clk     = 1'b0;
    rst_n   = 1'b0;
    x_valid = 1'b0;
    w_valid = 1'b0;
    y_valid = 1'b0;
    x_data  = '0;
    w_data  = '0;
    y_data  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset z_valid", 64'(0), 64'(z_valid));
    check_value("reset busy", 64'(0), 64'(busy));
    check_value("reset fault", 64'(0), 64'(fault));

    cur_test = "single";
    random_job(y, x, w);
    send_job(y, x, w, 0);
    drain_and_check();

    cur_test = "back_to_back";
    repeat (NUM_B2B) begin
      random_job(y, x, w);
      send_job(y, x, w, 0);
    end
    drain_and_check();

    cur_test = "w_gaps";
    repeat (NUM_GAP) begin
      random_job(y, x, w);
      send_job(y, x, w, MAX_GAP);
    end
    drain_and_check();

    // Wrap-around with all ones, zero bias and zero X
    cur_test = "edge";
    y.raw = '1;
    x.raw = '1;
    w     = '1;
    send_job(y, x, w, 0);
    random_job(y, x, w);
    y.raw = '0;
    x.raw = '1;
    send_job(y, x, w, 0);
    random_job(y, x, w);
    x.raw = '0;
    send_job(y, x, w, 1);
    random_job(y, x, w);
    y.raw = '1;
    w     = '1;
    send_job(y, x, w, 0);
    drain_and_check();

    cur_test = "final";
    check_value("final fault", 64'(0), 64'(fault));
    check_value("final expected queue", 64'(0), 64'(expected_q.size()));
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
hdl/matmul_pkg.sv
hdl/stream_fifo.sv
hdl/x_buffer.sv
hdl/mac_lanes.sv
hdl/job_scheduler.sv
hdl/lockstep_checker.sv
hdl/matmul_top.sv
verification/tb_matmul_top.sv

// File: Makefile
TOP = tb_matmul_top

.PHONY: sim clean

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
